// ==== rv32_execute_stage.f ====
+incdir+.
rv32_pkg.sv
rv32_alu.sv
rv32_csr_counters.sv
rv32_csrs.sv
rv32_execute.sv
rv32_execute_properties.sv
tb_rv32_execute.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_rv32_execute
LOG       ?= sim.log
FLAGS     ?= --assert
FILELIST  ?= rv32_execute_stage.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP LOG FLAGS FILELIST"

test:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_rv32_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module tb_rv32_execute;
    localparam int SETTLE_LIMIT = 20;
    localparam int RUN_LIMIT    = 2000;

    typedef struct packed {
        rv32_pkg::ex_in_t  in;
        rv32_pkg::wb_fwd_t wb;
        logic              stall;
        logic              flush;
        logic [7:0]        test;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              stall;
    logic              flush;
    rv32_pkg::ex_in_t  ex_in;
    rv32_pkg::wb_fwd_t wb;
    rv32_pkg::ex_out_t ex_out;

    row_t              rows[$];
    logic [31:0]       rng_state = 32'd17;
    rv32_pkg::ex_out_t expected;
    rv32_pkg::ex_out_t predicted;
    logic [31:0]       mscratch_model = '0;
    logic [63:0]       cycle_model = '0;
    logic [63:0]       instret_model = '0;
    logic [7:0]        prev_test;
    int                errors = 0;
    int                test_errors = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                run_cycles = 0;

    always #4 clk = ~clk;

    rv32_execute UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .ex_in  (ex_in),
        .wb     (wb),
        .ex_out (ex_out)
    );

    bind rv32_execute rv32_execute_properties props (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (flush),
        .ex_out (ex_out)
    );

    // Counter model, sampled on the same edges as the DUT.
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle_model   <= '0;
            instret_model <= '0;
        end else begin
            cycle_model <= cycle_model + 64'd1;
            if (wb.valid) begin
                instret_model <= instret_model + 64'd1;
            end
        end
    end

    always @(posedge clk) begin
        run_cycles <= run_cycles + 1;
        if (run_cycles > RUN_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic [31:0] pick_operand(input logic [4:0] src,
                                                 input logic [31:0] value,
                                                 input rv32_pkg::ex_out_t prev,
                                                 input rv32_pkg::wb_fwd_t w);
        if (src != 5'd0 && prev.rd_write && prev.rd == src) begin
            return prev.result;
        end
        if (src != 5'd0 && w.rd_write && w.rd == src) begin
            return w.rd_value;
        end
        return value;
    endfunction

    function automatic logic [31:0] alu_expect(input rv32_pkg::alu_op_e op, input logic sub,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            rv32_pkg::ALU_ADD:  return sub ? a - b : a + b;
            rv32_pkg::ALU_SLL:  return a << sh;
            rv32_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            rv32_pkg::ALU_XOR:  return a ^ b;
            rv32_pkg::ALU_SR:   return sub ? 32'($signed(a) >>> sh) : a >> sh;
            rv32_pkg::ALU_OR:   return a | b;
            rv32_pkg::ALU_AND:  return a & b;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] csr_expect(input logic [11:0] addr);
        case (addr)
            `RV32_CSR_MSCRATCH: return mscratch_model;
            `RV32_CSR_CYCLE:    return cycle_model[31:0];
            `RV32_CSR_CYCLEH:   return cycle_model[63:32];
            `RV32_CSR_INSTRET:  return instret_model[31:0];
            `RV32_CSR_INSTRETH: return instret_model[63:32];
            default:            return 32'd0;
        endcase
    endfunction

    // Next stage output for one row, given the output the stage holds now.
    function automatic rv32_pkg::ex_out_t stage_expect(input row_t r,
                                                       input rv32_pkg::ex_out_t cur);
        rv32_pkg::ex_out_t n;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        if (r.stall) begin
            return cur;
        end
        s1 = pick_operand(r.in.rs1, r.in.rs1_value, cur, r.wb);
        s2 = pick_operand(r.in.rs2, r.in.rs2_value, cur, r.wb);
        a = (r.in.ctrl.src1 == rv32_pkg::SRC1_RS1) ? s1 :
            (r.in.ctrl.src1 == rv32_pkg::SRC1_PC) ? r.in.pc : 32'd0;
        b = (r.in.ctrl.src2 == rv32_pkg::SRC2_RS2) ? s2 :
            (r.in.ctrl.src2 == rv32_pkg::SRC2_IMM) ? r.in.imm :
            (r.in.ctrl.src2 == rv32_pkg::SRC2_FOUR) ? 32'd4 : 32'd0;
        target = (r.in.ctrl.branch_pc_src ? s1 : r.in.pc) + r.in.imm;
        n = '0;
        n.valid = r.in.valid && !r.flush;
        n.mem = r.in.mem;
        n.mem.read = r.in.mem.read && !r.flush;
        n.mem.write = r.in.mem.write && !r.flush;
        n.branch_op = r.flush ? rv32_pkg::BRANCH_NEVER : r.in.ctrl.branch_op;
        n.rd = r.in.rd;
        n.rd_write = r.in.rd_write && !r.flush;
        n.result = r.in.ctrl.csr_read ? csr_expect(r.in.csr_addr) :
                   alu_expect(r.in.ctrl.alu_op, r.in.ctrl.sub_sra, a, b);
        n.rs2_value = s2;
        n.branch_pc = {target[31:1], 1'b0};
        return n;
    endfunction

    task automatic apply_csr_write(input row_t r, input rv32_pkg::ex_out_t prev);
        logic [31:0] v;
        v = r.in.ctrl.csr_src ? r.in.imm : pick_operand(r.in.rs1, r.in.rs1_value, prev, r.wb);
        if (r.in.valid && r.in.ctrl.csr_write && !r.stall && !r.flush &&
            r.in.csr_addr == `RV32_CSR_MSCRATCH) begin
            case (r.in.ctrl.csr_write_op)
                rv32_pkg::CSR_WRITE: mscratch_model = v;
                rv32_pkg::CSR_SET:   mscratch_model = mscratch_model | v;
                rv32_pkg::CSR_CLEAR: mscratch_model = mscratch_model & ~v;
                default:             mscratch_model = mscratch_model;
            endcase
        end
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("ERROR %0t ns %s got %0h expected %0h", $time, name, got, want);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_out(input rv32_pkg::ex_out_t exp);
        check("ex_out.valid", 64'(ex_out.valid), 64'(exp.valid));
        check("ex_out.mem", 64'(ex_out.mem), 64'(exp.mem));
        check("ex_out.branch_op", 64'(ex_out.branch_op), 64'(exp.branch_op));
        check("ex_out.rd", 64'(ex_out.rd), 64'(exp.rd));
        check("ex_out.rd_write", 64'(ex_out.rd_write), 64'(exp.rd_write));
        check("ex_out.result", 64'(ex_out.result), 64'(exp.result));
        check("ex_out.rs2_value", 64'(ex_out.rs2_value), 64'(exp.rs2_value));
        check("ex_out.branch_pc", 64'(ex_out.branch_pc), 64'(exp.branch_pc));
    endtask

    task automatic report_test(input logic [7:0] num);
        if (test_errors == 0) begin
            $display("Test %0d passed", num);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", num, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic wait_reset_settled();
        int n;
        n = 0;
        while (ex_out.valid !== 1'b0 && n < SETTLE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (ex_out.valid !== 1'b0) begin
            $display("Timeout: stage output valid never cleared after reset");
            errors++;
            test_errors++;
        end
    endtask

    // Random operands, no forwarding unless a row asks for it.
    function automatic row_t base_row(input logic [7:0] test);
        row_t r;
        r = '0;
        r.test = test;
        r.in.valid = 1'b1;
        r.in.rd_write = 1'b1;
        r.in.rd = 5'd20;
        r.in.pc = rand32() & 32'hFFFF_FFFC;
        r.in.rs1_value = rand32();
        r.in.rs2_value = rand32();
        r.in.imm = rand32();
        r.in.csr_addr = 12'h7C0;
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        logic [31:0] t;
        for (int k = 0; k < 16; k++) begin
            r = base_row(8'd1);
            r.in.ctrl.alu_op = rv32_pkg::alu_op_e'(3'(k));
            r.in.ctrl.sub_sra = k[3];
            r.in.ctrl.src1 = rv32_pkg::alu_src1_e'(2'(k % 3));
            r.in.ctrl.src2 = rv32_pkg::alu_src2_e'(2'((k + 1) % 3));
            r.in.rd = 5'(k + 1);
            rows.push_back(r);
        end
        for (int k = 0; k < 2; k++) begin  // Logical and arithmetic shift of a negative rs1.
            r = base_row(8'd1);
            r.in.ctrl.alu_op = rv32_pkg::ALU_SR;
            r.in.ctrl.sub_sra = k[0];
            r.in.ctrl.src2 = rv32_pkg::SRC2_IMM;
            r.in.rs1_value[31] = 1'b1;
            r.in.imm[4] = 1'b1;            // Shift by at least 16.
            rows.push_back(r);
        end
        r = base_row(8'd2);
        r.in.rd = 5'd5;
        rows.push_back(r);
        r = base_row(8'd2);                 // Own result beats writeback.
        r.in.rs1 = 5'd5;
        r.in.rs2 = 5'd7;
        r.in.rd = 5'd8;
        r.wb = '{valid: 1'b1, rd: 5'd5, rd_write: 1'b1, rd_value: rand32()};
        rows.push_back(r);
        r = base_row(8'd2);
        r.in.rs1 = 5'd9;
        r.in.rs2 = 5'd9;
        r.in.rd = 5'd0;
        r.wb = '{valid: 1'b0, rd: 5'd9, rd_write: 1'b1, rd_value: rand32()};
        rows.push_back(r);
        r = base_row(8'd2);                 // x0 is never forwarded.
        r.wb = '{valid: 1'b1, rd: 5'd0, rd_write: 1'b1, rd_value: rand32()};
        rows.push_back(r);
        r = base_row(8'd3);
        r.in.csr_addr = `RV32_CSR_MSCRATCH;
        r.in.ctrl.csr_read = 1'b1;
        r.in.ctrl.csr_write = 1'b1;
        r.in.ctrl.csr_write_op = rv32_pkg::CSR_WRITE;
        r.in.ctrl.csr_src = 1'b1;
        r.in.mem.read = 1'b1;
        r.in.mem.write = 1'b1;
        r.in.ctrl.branch_op = rv32_pkg::BRANCH_ALWAYS;
        r.stall = 1'b1;
        rows.push_back(r);
        rows.push_back(r);
        r.stall = 1'b0;
        r.flush = 1'b1;
        rows.push_back(r);
        r = base_row(8'd3);
        r.in.csr_addr = `RV32_CSR_MSCRATCH;
        r.in.ctrl.csr_read = 1'b1;
        rows.push_back(r);
        for (int k = 0; k < 3; k++) begin  // Write, set and clear in turn.
            r = base_row(8'd4);
            r.in.csr_addr = `RV32_CSR_MSCRATCH;
            r.in.ctrl.csr_read = 1'b1;
            r.in.ctrl.csr_write = 1'b1;
            r.in.ctrl.csr_write_op = rv32_pkg::csr_write_op_e'(2'(k + 1));
            r.in.ctrl.csr_src = k[0];
            rows.push_back(r);
        end
        r = base_row(8'd4);
        r.in.csr_addr = `RV32_CSR_MSCRATCH;
        r.in.ctrl.csr_read = 1'b1;
        r.wb.valid = 1'b1;
        rows.push_back(r);
        r.in.csr_addr = 12'h7C0;
        rows.push_back(r);
        rows.push_back(r);
        r.wb.valid = 1'b0;
        r.in.csr_addr = `RV32_CSR_INSTRET;
        rows.push_back(r);
        r.in.csr_addr = `RV32_CSR_INSTRETH;
        rows.push_back(r);
        r.in.csr_addr = `RV32_CSR_CYCLE;
        rows.push_back(r);
        rows.push_back(r);
        r.in.csr_addr = `RV32_CSR_CYCLEH;
        rows.push_back(r);
        for (int k = 0; k < 4; k++) begin
            r = base_row(8'd5);
            t = rand32();
            r.in.ctrl.branch_op = rv32_pkg::branch_op_e'(t[1:0]);
            r.in.ctrl.branch_pc_src = t[2];
            r.in.mem.read = t[3];
            r.in.mem.write = t[4];
            r.in.mem.width = t[5] ? rv32_pkg::MEM_HALF : rv32_pkg::MEM_WORD;
            r.in.mem.zero_extend = t[6];
            r.in.mem.fence = t[7];
            rows.push_back(r);
        end
        r = base_row(8'd5);
        r.in.rd = 5'd12;
        rows.push_back(r);
        r = base_row(8'd5);                 // jalr base comes from the forwarded rs1.
        r.in.rs1 = 5'd12;
        r.in.ctrl.branch_pc_src = 1'b1;
        r.in.ctrl.branch_op = rv32_pkg::BRANCH_ALWAYS;
        rows.push_back(r);
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        ex_in = '0;
        wb = '0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_settled();
        @(negedge clk);
        expected = '0;
        expected.branch_op = rv32_pkg::BRANCH_NEVER;
        prev_test = 8'd1;
        compare_out(expected);
        foreach (rows[i]) begin
            @(posedge clk);
            ex_in <= rows[i].in;
            wb <= rows[i].wb;
            stall <= rows[i].stall;
            flush <= rows[i].flush;
            @(negedge clk);
            compare_out(expected);
            if (rows[i].test != prev_test) begin
                report_test(prev_test);
                prev_test = rows[i].test;
            end
            predicted = stage_expect(rows[i], expected);
            apply_csr_write(rows[i], expected);
            expected = predicted;
        end
        @(posedge clk);
        ex_in <= '0;
        wb <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        compare_out(expected);
        report_test(prev_test);
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_execute_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_execute_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              stall,
    input logic              flush,
    input rv32_pkg::ex_out_t ex_out
);

    // A reset edge always leaves an empty stage behind.
    reset_clears_valid: assert property (
        @(posedge clk) !rst_n |=> !ex_out.valid
    ) else $error("ex_out.valid is set after a reset cycle");

    stall_holds_output: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(ex_out)
    ) else $error("ex_out changed across a stalled cycle");

    // Flush kills everything that could change state downstream.
    flush_kills_control: assert property (
        @(posedge clk) disable iff (!rst_n)
        (flush && !stall) |=> (!ex_out.valid && !ex_out.rd_write &&
                               !ex_out.mem.read && !ex_out.mem.write)
    ) else $error("control fields survived a flush");

endmodule

`default_nettype wire

// ==== rv32_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,   // From the hazard unit, holds the stage.
    input  logic              flush,   // Kills the instruction on ex_in.
    input  rv32_pkg::ex_in_t  ex_in,
    input  rv32_pkg::wb_fwd_t wb,
    output rv32_pkg::ex_out_t ex_out
);
    logic [`RV32_XLEN-1:0] rs1_fwd;
    logic [`RV32_XLEN-1:0] rs2_fwd;
    logic [`RV32_XLEN-1:0] alu_result;
    logic [`RV32_XLEN-1:0] csr_read_value;
    logic [`RV32_XLEN-1:0] csr_write_value;
    logic                  csr_write_en;
    logic [`RV32_XLEN-1:0] branch_base;
    logic [`RV32_XLEN-1:0] branch_sum;
    logic [`RV32_XLEN-1:0] branch_pc;
    logic [`RV32_XLEN-1:0] stage_result;

    // The youngest producer wins, so our own register beats writeback.
    function automatic logic [`RV32_XLEN-1:0] forward(
        input logic [`RV32_REG_W-1:0] src,
        input logic [`RV32_XLEN-1:0]  value,
        input rv32_pkg::ex_out_t      prev,
        input rv32_pkg::wb_fwd_t      wb_in
    );
        if (src == '0) begin
            return value;  // x0 is hardwired to zero.
        end else if (prev.rd_write && prev.rd == src) begin
            return prev.result;
        end else if (wb_in.rd_write && wb_in.rd == src) begin
            return wb_in.rd_value;
        end
        return value;
    endfunction

    assign rs1_fwd = forward(ex_in.rs1, ex_in.rs1_value, ex_out, wb);
    assign rs2_fwd = forward(ex_in.rs2, ex_in.rs2_value, ex_out, wb);

    rv32_alu alu (
        .op        (ex_in.ctrl.alu_op),
        .sub_sra   (ex_in.ctrl.sub_sra),
        .src1      (ex_in.ctrl.src1),
        .src2      (ex_in.ctrl.src2),
        .pc        (ex_in.pc),
        .rs1_value (rs1_fwd),
        .rs2_value (rs2_fwd),
        .imm       (ex_in.imm),
        .result    (alu_result)
    );

    // A held or killed instruction must not touch mscratch.
    assign csr_write_en    = ex_in.valid && ex_in.ctrl.csr_write && !stall && !flush;
    assign csr_write_value = ex_in.ctrl.csr_src ? ex_in.imm : rs1_fwd;

    rv32_csrs csrs (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (csr_write_en),
        .write_op    (ex_in.ctrl.csr_write_op),
        .write_value (csr_write_value),
        .addr        (ex_in.csr_addr),
        .retire      (wb.valid),
        .read_value  (csr_read_value)
    );

    // Branches use pc, jalr uses rs1. Bit 0 is always dropped.
    assign branch_base = ex_in.ctrl.branch_pc_src ? rs1_fwd : ex_in.pc;
    assign branch_sum  = branch_base + ex_in.imm;
    assign branch_pc   = {branch_sum[`RV32_XLEN-1:1], 1'b0};

    assign stage_result = ex_in.ctrl.csr_read ? csr_read_value : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_out           <= '0;
            ex_out.branch_op <= rv32_pkg::BRANCH_NEVER;
        end else if (!stall) begin
            // Flush clears only what could change architectural state.
            ex_out.valid           <= ex_in.valid && !flush;
            ex_out.mem.read        <= ex_in.mem.read && !flush;
            ex_out.mem.write       <= ex_in.mem.write && !flush;
            ex_out.mem.width       <= ex_in.mem.width;
            ex_out.mem.zero_extend <= ex_in.mem.zero_extend;
            ex_out.mem.fence       <= ex_in.mem.fence;
            ex_out.branch_op       <= flush ? rv32_pkg::BRANCH_NEVER : ex_in.ctrl.branch_op;
            ex_out.rd              <= ex_in.rd;
            ex_out.rd_write        <= ex_in.rd_write && !flush;
            ex_out.result          <= stage_result;
            ex_out.rs2_value       <= rs2_fwd;  // Store data, already forwarded.
            ex_out.branch_pc       <= branch_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rv32_csrs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_csrs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          write_en,
    input  rv32_pkg::csr_write_op_e       write_op,
    input  logic [`RV32_XLEN-1:0]         write_value,  // rs1 or zimm.
    input  logic [`RV32_CSR_W-1:0]        addr,
    input  logic                          retire,
    output logic [`RV32_XLEN-1:0]         read_value
);
    logic [`RV32_XLEN-1:0] mscratch;
    logic [`RV32_XLEN-1:0] mscratch_next;
    logic                  mscratch_sel;
    logic [63:0]           cycle;
    logic [63:0]           instret;

    rv32_csr_counters counters (
        .clk     (clk),
        .rst_n   (rst_n),
        .retire  (retire),
        .cycle   (cycle),
        .instret (instret)
    );

    // Address decode and read mux, purely from the current state.
    always_comb begin
        mscratch_sel = 1'b0;
        case (addr)
            `RV32_CSR_MSCRATCH: begin
                mscratch_sel = 1'b1;
                read_value   = mscratch;
            end
            `RV32_CSR_CYCLE:    read_value = cycle[31:0];
            `RV32_CSR_CYCLEH:   read_value = cycle[63:32];
            `RV32_CSR_INSTRET:  read_value = instret[31:0];
            `RV32_CSR_INSTRETH: read_value = instret[63:32];
            default:            read_value = '0;  // Unknown CSRs read as zero.
        endcase
    end

    // New mscratch value for csrrw, csrrs and csrrc.
    always_comb begin
        case (write_op)
            rv32_pkg::CSR_WRITE: mscratch_next = write_value;
            rv32_pkg::CSR_SET:   mscratch_next = mscratch | write_value;
            rv32_pkg::CSR_CLEAR: mscratch_next = mscratch & ~write_value;
            default:             mscratch_next = mscratch;
        endcase
    end

    // The counters are read only, so only a write to mscratch lands anywhere.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (write_en && mscratch_sel) begin
            mscratch <= mscratch_next;
        end
    end

endmodule

`default_nettype wire

// ==== rv32_csr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_csr_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        retire,   // One pulse per instruction leaving writeback.
    output logic [63:0] cycle,
    output logic [63:0] instret
);

    // Free running, wraps at 2**64.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instret <= '0;
        end else if (retire) begin
            instret <= instret + 64'd1;  // Counts on the retire edge itself.
        end
    end

endmodule

`default_nettype wire

// ==== rv32_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_macros.svh"

module rv32_alu (
    input  rv32_pkg::alu_op_e     op,
    input  logic                  sub_sra,
    input  rv32_pkg::alu_src1_e   src1,
    input  rv32_pkg::alu_src2_e   src2,
    input  logic [`RV32_XLEN-1:0] pc,
    input  logic [`RV32_XLEN-1:0] rs1_value,
    input  logic [`RV32_XLEN-1:0] rs2_value,
    input  logic [`RV32_XLEN-1:0] imm,
    output logic [`RV32_XLEN-1:0] result
);
    localparam int SHAMT_W = $clog2(`RV32_XLEN);

    logic [`RV32_XLEN-1:0] a;
    logic [`RV32_XLEN-1:0] b;
    logic [SHAMT_W-1:0]    shamt;
    logic [`RV32_XLEN-1:0] sum;
    logic [`RV32_XLEN-1:0] shift_right;

    always_comb begin
        case (src1)
            rv32_pkg::SRC1_RS1: a = rs1_value;
            rv32_pkg::SRC1_PC:  a = pc;         // auipc, jal and jalr.
            default:            a = '0;         // lui adds the immediate to zero.
        endcase
    end

    always_comb begin
        case (src2)
            rv32_pkg::SRC2_RS2:  b = rs2_value;
            rv32_pkg::SRC2_IMM:  b = imm;
            rv32_pkg::SRC2_FOUR: b = `RV32_XLEN'd4;
            default:             b = '0;
        endcase
    end

    assign shamt = b[SHAMT_W-1:0];  // Only the low bits of operand 2 count.

    assign sum = sub_sra ? a - b : a + b;

    // The signed cast keeps the sign bit flowing in for sra and srai.
    assign shift_right = sub_sra ? `RV32_XLEN'($signed(a) >>> shamt) : a >> shamt;

    always_comb begin
        case (op)
            rv32_pkg::ALU_ADD:  result = sum;
            rv32_pkg::ALU_SLL:  result = a << shamt;
            rv32_pkg::ALU_SLT:  result = {{(`RV32_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv32_pkg::ALU_SLTU: result = {{(`RV32_XLEN-1){1'b0}}, a < b};
            rv32_pkg::ALU_XOR:  result = a ^ b;
            rv32_pkg::ALU_SR:   result = shift_right;
            rv32_pkg::ALU_OR:   result = a | b;
            rv32_pkg::ALU_AND:  result = a & b;
            default:            result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv32_pkg.sv ====
`default_nettype none

`include "rv32_macros.svh"

package rv32_pkg;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,  // Also subtract when sub_sra is set.
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,  // Logical, or arithmetic when sub_sra is set.
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS1  = 2'b00,
        SRC1_PC   = 2'b01,
        SRC1_ZERO = 2'b10
    } alu_src1_e;

    typedef enum logic [1:0] {
        SRC2_RS2  = 2'b00,
        SRC2_IMM  = 2'b01,
        SRC2_FOUR = 2'b10  // Return address for jal and jalr.
    } alu_src2_e;

    typedef enum logic [1:0] {
        BRANCH_NEVER    = 2'b00,
        BRANCH_ZERO     = 2'b01,  // Taken when the result is zero.
        BRANCH_NON_ZERO = 2'b10,
        BRANCH_ALWAYS   = 2'b11
    } branch_op_e;

    // Encoded as the low bits of funct3 of csrrw, csrrs and csrrc.
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_write_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    typedef struct packed {
        logic       read;
        logic       write;
        mem_width_e width;
        logic       zero_extend;  // Load without sign extension.
        logic       fence;
    } mem_ctrl_t;

    typedef struct packed {
        alu_op_e       alu_op;
        logic          sub_sra;
        alu_src1_e     src1;
        alu_src2_e     src2;
        logic          csr_read;
        logic          csr_write;
        csr_write_op_e csr_write_op;
        logic          csr_src;        // Set selects the immediate as zimm.
        branch_op_e    branch_op;
        logic          branch_pc_src;  // Set selects rs1 as the target base.
    } ex_ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV32_REG_W-1:0] rs1;
        logic [`RV32_REG_W-1:0] rs2;
        logic [`RV32_REG_W-1:0] rd;
        logic                   rd_write;
        logic [`RV32_XLEN-1:0]  pc;
        logic [`RV32_XLEN-1:0]  rs1_value;
        logic [`RV32_XLEN-1:0]  rs2_value;
        logic [`RV32_XLEN-1:0]  imm;
        logic [`RV32_CSR_W-1:0] csr_addr;
        ex_ctrl_t               ctrl;
        mem_ctrl_t              mem;
    } ex_in_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV32_REG_W-1:0] rd;
        logic                   rd_write;
        logic [`RV32_XLEN-1:0]  rd_value;
    } wb_fwd_t;

    typedef struct packed {
        logic                   valid;
        mem_ctrl_t              mem;
        branch_op_e             branch_op;
        logic [`RV32_REG_W-1:0] rd;
        logic                   rd_write;
        logic [`RV32_XLEN-1:0]  result;     // ALU result or CSR read value.
        logic [`RV32_XLEN-1:0]  rs2_value;  // Store data.
        logic [`RV32_XLEN-1:0]  branch_pc;
    } ex_out_t;

endpackage

`default_nettype wire

// ==== rv32_macros.svh ====
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

// Datapath and field widths.
`define RV32_XLEN  32  // Data word width.
`define RV32_REG_W 5   // Register address width.
`define RV32_CSR_W 12  // CSR address width.

// Supported CSR addresses.
`define RV32_CSR_MSCRATCH 12'h340  // Machine scratch register, read/write.
`define RV32_CSR_CYCLE    12'hC00  // Low half of the cycle counter.
`define RV32_CSR_CYCLEH   12'hC80  // High half of the cycle counter.
`define RV32_CSR_INSTRET  12'hC02  // Low half of the retired instruction counter.
`define RV32_CSR_INSTRETH 12'hC82  // High half of the retired instruction counter.

`endif
